/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/mem_access.sv
verilog/mem_route.sv
verilog/mem_clint.sv
verilog/mem_stage.sv
test/tb_mem_stage.sv

/* test/tb_mem_stage.sv */
`timescale 1ns/10ps

module tb_mem_stage;

    localparam int CLK_HALF = 10;
    localparam int OP_NONE = 0, OP_LD = 1, OP_ST = 2;
    localparam int FW_NONE = 0, FW_HIT = 1, FW_ZERO = 2, FW_OFF = 3;
    localparam int F_RD = 1, F_NOEXT = 2, F_MTIP0 = 4, F_MTIP1 = 8, F_MT = 16;
    localparam logic [2:0] T_SB = 3'(mem_pkg::ST_B), T_SH = 3'(mem_pkg::ST_H);
    localparam logic [2:0] T_SW = 3'(mem_pkg::ST_W), T_SD = 3'(mem_pkg::ST_D);
    localparam logic [63:0] MB = 64'h0000_0000_8000_0000;     // External memory.
    localparam logic [63:0] CMP = 64'h0000_0000_0200_4000;    // CLINT mtimecmp.
    localparam logic [63:0] MTIME = 64'h0000_0000_0200_bff8;

    logic clk;
    logic rst_n_i, inst_valid_i, mem_read_i, mem_write_i, rs2_en_i, wb_rd_en_i;
    mem_pkg::load_type_e  load_type_i;
    mem_pkg::store_type_e store_type_i;
    mem_pkg::reg_idx_t    rs2_index_i, wb_rd_index_i;
    mem_pkg::data_t       rs2_data_i, ex_result_i, wb_rd_data_i, rd_data_o;
    logic access_ok_o, fault_o, mtip_o, mem_valid_o, mem_write_o;
    mem_pkg::addr_t mem_addr_o;
    mem_pkg::size_t mem_size_o;
    mem_pkg::data_t mem_wdata_o;
    logic           mem_ready_i = 1'b0;
    mem_pkg::data_t mem_rdata_i = '0;
    mem_pkg::resp_e mem_resp_i = mem_pkg::RESP_OKAY;

    logic [7:0]  mem [0:4095];
    logic        pending = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;
    int          seed = 32'h70f8_c6c1;
    int          n_checks = 0, n_errors = 0;
    logic [63:0] last_mtime = '0;
    logic        have_mtime = 1'b0;

    string names[$];
    int ops[$], fwds[$], faults[$], flags[$];
    logic [2:0] types[$];
    logic [63:0] addrs[$], datas[$], exps[$];

    mem_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Memory writes land on the bytes covered by size and offset.
    always @(posedge clk) begin
        pending <= mem_valid_o & ~mem_ready_i;
        if (mem_valid_o && mem_ready_i && mem_write_o) begin
            for (int k = 0; k < 8; k++) begin
                if (k >= int'(mem_addr_o[2:0]) && k < int'(mem_addr_o[2:0]) + (1 << mem_size_o))
                    mem[{mem_addr_o[11:3], 3'(k)}] = mem_wdata_o[8*k +: 8];
            end
        end
    end

    always @(negedge clk) begin
        if (pending) begin
            if (wait_cnt == 2'd0) begin
                mem_ready_i <= 1'b1;
                mem_rdata_i <= read_word(mem_addr_o);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else begin
            mem_ready_i <= 1'b0;
            wait_cnt <= 2'($random(seed));                 // Next wait, 0 to 3.
        end
    end

    function automatic logic [63:0] read_word(input logic [63:0] addr);
        logic [63:0] w;
        for (int k = 0; k < 8; k++) begin
            w[8*k +: 8] = mem[{addr[11:3], 3'(k)}];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic add_row(input string name, input int op, input logic [2:0] typ,
                           input logic [63:0] addr, input logic [63:0] data, input int fwd,
                           input logic [63:0] exp, input int fault, input int flag);
        names.push_back(name);
        ops.push_back(op);
        types.push_back(typ);
        addrs.push_back(addr);
        datas.push_back(data);
        fwds.push_back(fwd);
        exps.push_back(exp);
        faults.push_back(fault);
        flags.push_back(flag);
    endtask

    task automatic drive_row(input int i);
        inst_valid_i = 1'b1;
        mem_read_i = (ops[i] == OP_LD);
        mem_write_i = (ops[i] == OP_ST);
        load_type_i = mem_pkg::load_type_e'(types[i]);
        store_type_i = mem_pkg::store_type_e'(types[i][1:0]);
        ex_result_i = addrs[i];
        rs2_data_i = datas[i];
        wb_rd_data_i = ~datas[i];                          // Differs from rs2 on purpose.
        rs2_en_i = 1'b1;
        rs2_index_i = (fwds[i] == FW_ZERO) ? 5'd0 : 5'd5;
        wb_rd_index_i = (fwds[i] == FW_NONE) ? 5'd6 : rs2_index_i;
        wb_rd_en_i = (fwds[i] != FW_OFF);
    endtask

    task run_row(input int i);
        logic ext_seen;
        logic done;
        @(negedge clk);
        drive_row(i);
        ext_seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            #(CLK_HALF / 2);                               // Mid low phase, all settled.
            ext_seen = ext_seen | mem_valid_o;
            done = access_ok_o;
            if (!done)
                @(negedge clk);
        end
        check_value(names[i], "fault", 64'(faults[i]), 64'(fault_o));
        if ((flags[i] & F_RD) != 0)
            check_value(names[i], "rd_data", exps[i], rd_data_o);
        if ((flags[i] & F_NOEXT) != 0)
            check_value(names[i], "mem_valid", '0, 64'(ext_seen));
        if ((flags[i] & F_MTIP0) != 0)
            check_value(names[i], "mtip", '0, 64'(mtip_o));
        if ((flags[i] & F_MTIP1) != 0)
            check_value(names[i], "mtip", 64'd1, 64'(mtip_o));
        if ((flags[i] & F_MT) != 0) begin
            if (have_mtime)
                check_value(names[i], "mtime order", 64'd1, 64'(rd_data_o >= last_mtime));
            last_mtime = rd_data_o;
            have_mtime = 1'b1;
        end
    endtask

    task automatic build_table();
        add_row("sd_0", OP_ST, T_SD, MB, 64'hf1e2_d3c4_b5a6_9788, 0, '0, 0, 0);
        add_row("sd_8", OP_ST, T_SD, MB + 8, 64'h0123_4567_7654_3210, 0, '0, 0, 0);
        add_row("lb_0", OP_LD, mem_pkg::LD_B, MB, '0, 0, 64'hffff_ffff_ffff_ff88, 0, F_RD);
        add_row("lbu_1", OP_LD, mem_pkg::LD_BU, MB + 1, '0, 0, 64'h97, 0, F_RD);
        add_row("lb_7", OP_LD, mem_pkg::LD_B, MB + 7, '0, 0, 64'hffff_ffff_ffff_fff1, 0, F_RD);
        add_row("lh_2", OP_LD, mem_pkg::LD_H, MB + 2, '0, 0, 64'hffff_ffff_ffff_b5a6, 0, F_RD);
        add_row("lhu_6", OP_LD, mem_pkg::LD_HU, MB + 6, '0, 0, 64'hf1e2, 0, F_RD);
        add_row("lw_4", OP_LD, mem_pkg::LD_W, MB + 4, '0, 0, 64'hffff_ffff_f1e2_d3c4, 0, F_RD);
        add_row("lwu_0", OP_LD, mem_pkg::LD_WU, MB, '0, 0, 64'h0000_0000_b5a6_9788, 0, F_RD);
        add_row("lw_8", OP_LD, mem_pkg::LD_W, MB + 8, '0, 0, 64'h0000_0000_7654_3210, 0, F_RD);
        add_row("ld_0", OP_LD, mem_pkg::LD_D, MB, '0, 0, 64'hf1e2_d3c4_b5a6_9788, 0, F_RD);
        add_row("sd_18", OP_ST, T_SD, MB + 24, '0, 0, '0, 0, 0);
        add_row("sb_19", OP_ST, T_SB, MB + 25, 64'h55ab, 0, '0, 0, 0);
        add_row("sh_1a", OP_ST, T_SH, MB + 26, 64'h9876_cdef, 0, '0, 0, 0);
        add_row("sw_1c", OP_ST, T_SW, MB + 28, 64'haaaa_bbbb_1122_3344, 0, '0, 0, 0);
        add_row("ld_18", OP_LD, mem_pkg::LD_D, MB + 24, '0, 0, 64'h1122_3344_cdef_ab00, 0, F_RD);
        add_row("sd_fwd_hit", OP_ST, T_SD, MB + 32, 64'h1111_2222_3333_4444, FW_HIT, '0, 0, 0);
        add_row("ld_fwd_hit", OP_LD, mem_pkg::LD_D, MB + 32, '0, 0, 64'heeee_dddd_cccc_bbbb, 0, F_RD);
        add_row("sd_fwd_x0", OP_ST, T_SD, MB + 40, 64'h5555_6666_7777_8888, FW_ZERO, '0, 0, 0);
        add_row("ld_fwd_x0", OP_LD, mem_pkg::LD_D, MB + 40, '0, 0, 64'h5555_6666_7777_8888, 0, F_RD);
        add_row("sd_fwd_off", OP_ST, T_SD, MB + 48, 64'h9999_aaaa_bbbb_cccc, FW_OFF, '0, 0, 0);
        add_row("ld_fwd_off", OP_LD, mem_pkg::LD_D, MB + 48, '0, 0, 64'h9999_aaaa_bbbb_cccc, 0, F_RD);
        add_row("alu_op", OP_NONE, mem_pkg::LD_D, 64'hcafe_f00d, '0, 0, 64'hcafe_f00d, 0,
                F_RD | F_NOEXT);
        add_row("sd_cmp_0", OP_ST, T_SD, CMP, '0, 0, '0, 0, F_NOEXT);
        add_row("ld_cmp_0", OP_LD, mem_pkg::LD_D, CMP, '0, 0, '0, 0, F_RD | F_NOEXT | F_MTIP1);
        add_row("sd_cmp_1", OP_ST, T_SD, CMP, '1, 0, '0, 0, F_NOEXT);
        add_row("ld_cmp_1", OP_LD, mem_pkg::LD_D, CMP, '0, 0, '1, 0, F_RD | F_NOEXT | F_MTIP0);
        add_row("ld_mtime_a", OP_LD, mem_pkg::LD_D, MTIME, '0, 0, '0, 0, F_NOEXT | F_MT);
        add_row("ld_mtime_b", OP_LD, mem_pkg::LD_D, MTIME, '0, 0, '0, 0, F_NOEXT | F_MT);
        add_row("lh_mis", OP_LD, mem_pkg::LD_H, MB + 1, '0, 0, '0, 1, F_NOEXT);
        add_row("lw_mis", OP_LD, mem_pkg::LD_W, MB + 2, '0, 0, '0, 1, F_NOEXT);
        add_row("sd_mis", OP_ST, T_SD, MB + 4, '0, 0, '0, 1, F_NOEXT);
        add_row("ld_clint_ofs", OP_LD, mem_pkg::LD_D, CMP + 8, '0, 0, '0, 1, F_NOEXT);
        add_row("lw_clint", OP_LD, mem_pkg::LD_W, CMP, '0, 0, '0, 1, F_NOEXT);
    endtask

    // Budget of 20 cycles per row.
    initial begin
        #1;
        repeat (names.size() * 20 + 8) @(posedge clk);
        $display("Watchdog expired: a row never completed.");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        inst_valid_i = 1'b0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        load_type_i = mem_pkg::LD_D;
        store_type_i = mem_pkg::ST_D;
        rs2_en_i = 1'b0;
        rs2_index_i = '0;
        rs2_data_i = '0;
        ex_result_i = '0;
        wb_rd_en_i = 1'b0;
        wb_rd_index_i = '0;
        wb_rd_data_i = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        check_value("reset", "mem_valid", '0, 64'(mem_valid_o));
        check_value("reset", "mtip", '0, 64'(mtip_o));
        for (int i = 0; i < names.size(); i++) begin
            run_row(i);
        end
        @(negedge clk);
        inst_valid_i = 1'b0;
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog/mem_access.sv */
`timescale 1ns/10ps

module mem_access (
    input  logic                    inst_valid_i,
    input  logic                    mem_read_i,
    input  logic                    mem_write_i,
    input  mem_pkg::load_type_e     load_type_i,
    input  mem_pkg::store_type_e    store_type_i,
    input  logic                    rs2_en_i,
    input  mem_pkg::reg_idx_t       rs2_index_i,
    input  mem_pkg::data_t          rs2_data_i,
    input  mem_pkg::data_t          ex_result_i,
    input  logic                    wb_rd_en_i,
    input  mem_pkg::reg_idx_t       wb_rd_index_i,
    input  mem_pkg::data_t          wb_rd_data_i,
    output mem_pkg::data_t          rd_data_o,
    output logic                    access_ok_o,
    output logic                    fault_o,
    mem_bus_if.master               bus
);

    logic                fwd_hit;
    mem_pkg::data_t      store_data;
    mem_pkg::addr_t      acc_addr;
    mem_pkg::size_t      acc_size;
    logic                is_mem;
    logic                misalign;
    logic                done;
    mem_pkg::mem_lane_u  wr_lanes;
    mem_pkg::mem_lane_u  rd_lanes;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;
    logic [31:0]         word_sel;
    mem_pkg::data_t      load_ext;

    // Write-back result overrides a stale rs2.
    assign fwd_hit    = rs2_en_i & wb_rd_en_i & (rs2_index_i == wb_rd_index_i)
                        & (rs2_index_i != '0);
    assign store_data = fwd_hit ? wb_rd_data_i : rs2_data_i;

    assign acc_addr = ex_result_i;                          // Address from execute.
    assign is_mem   = inst_valid_i & (mem_read_i | mem_write_i);

    always_comb begin
        if (mem_write_i) begin
            case (store_type_i)
                mem_pkg::ST_B: acc_size = mem_pkg::SZ_B;
                mem_pkg::ST_H: acc_size = mem_pkg::SZ_H;
                mem_pkg::ST_W: acc_size = mem_pkg::SZ_W;
                default:       acc_size = mem_pkg::SZ_D;
            endcase
        end else begin
            case (load_type_i)
                mem_pkg::LD_B, mem_pkg::LD_BU: acc_size = mem_pkg::SZ_B;
                mem_pkg::LD_H, mem_pkg::LD_HU: acc_size = mem_pkg::SZ_H;
                mem_pkg::LD_W, mem_pkg::LD_WU: acc_size = mem_pkg::SZ_W;
                default:                       acc_size = mem_pkg::SZ_D;
            endcase
        end
    end

    always_comb begin
        case (acc_size)
            mem_pkg::SZ_H: misalign = acc_addr[0];
            mem_pkg::SZ_W: misalign = |acc_addr[1:0];
            mem_pkg::SZ_D: misalign = |acc_addr[2:0];
            default:       misalign = 1'b0;
        endcase
    end

    // Store data moved onto the addressed lanes.
    always_comb begin
        wr_lanes.d = '0;
        case (acc_size)
            mem_pkg::SZ_B: wr_lanes.b[acc_addr[2:0]] = store_data[7:0];
            mem_pkg::SZ_H: wr_lanes.h[acc_addr[2:1]] = store_data[15:0];
            mem_pkg::SZ_W: wr_lanes.w[acc_addr[2]]   = store_data[31:0];
            default:       wr_lanes.d                = store_data;
        endcase
    end

    assign bus.valid = is_mem & ~misalign;                  // Misaligned never leaves.
    assign bus.write = mem_write_i;
    assign bus.addr  = acc_addr;
    assign bus.size  = acc_size;
    assign bus.wdata = wr_lanes.d;

    assign rd_lanes.d = bus.rdata;
    assign byte_sel   = rd_lanes.b[acc_addr[2:0]];
    assign half_sel   = rd_lanes.h[acc_addr[2:1]];
    assign word_sel   = rd_lanes.w[acc_addr[2]];

    always_comb begin
        case (load_type_i)
            mem_pkg::LD_B:  load_ext = {{56{byte_sel[7]}}, byte_sel};
            mem_pkg::LD_H:  load_ext = {{48{half_sel[15]}}, half_sel};
            mem_pkg::LD_W:  load_ext = {{32{word_sel[31]}}, word_sel};
            mem_pkg::LD_BU: load_ext = {56'd0, byte_sel};
            mem_pkg::LD_HU: load_ext = {48'd0, half_sel};
            mem_pkg::LD_WU: load_ext = {32'd0, word_sel};
            default:        load_ext = rd_lanes.d;
        endcase
    end

    assign done = bus.valid & bus.ready;

    // Non-memory instructions pass straight through.
    assign access_ok_o = is_mem ? (misalign | done) : 1'b1;
    assign fault_o     = is_mem & (misalign | (done & (bus.resp == mem_pkg::RESP_ERROR)));
    assign rd_data_o   = (mem_read_i & ~mem_write_i) ? load_ext : ex_result_i;

endmodule

/* verilog/mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if;

    logic              valid;
    logic              write;
    mem_pkg::addr_t    addr;
    mem_pkg::size_t    size;
    mem_pkg::data_t    wdata;
    logic              ready;
    mem_pkg::data_t    rdata;
    mem_pkg::resp_e    resp;

    modport master (
        output valid, write, addr, size, wdata,
        input  ready, rdata, resp
    );

    modport slave (
        input  valid, write, addr, size, wdata,
        output ready, rdata, resp
    );

endinterface

/* verilog/mem_clint.sv */
`timescale 1ns/10ps

module mem_clint #(
    parameter int unsigned TICK_DIV = 1
) (
    input  logic         clk,
    input  logic         rst_n_i,
    mem_bus_if.slave     bus,
    output logic         mtip_o
);

    localparam int unsigned DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0]  div_cnt;
    logic              tick;
    mem_pkg::data_t    mtime;
    mem_pkg::data_t    mtimecmp;
    logic              ack_q;
    logic              sel_cmp;
    logic              sel_time;
    logic              acc_ok;

    assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
            mtime   <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            mtime   <= mtime + 64'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sel_cmp  = (bus.addr == mem_pkg::CLINT_MTIMECMP_OFS);
    assign sel_time = (bus.addr == mem_pkg::CLINT_MTIME_OFS);

    // Doubleword only; mtime is read-only.
    assign acc_ok = (bus.size == mem_pkg::SZ_D) & (sel_cmp | (sel_time & ~bus.write));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.valid & ~ack_q;                    // One ack per request.
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtimecmp <= '1;                                 // No interrupt out of reset.
        end else if (bus.valid & ack_q & bus.write & acc_ok & sel_cmp) begin
            mtimecmp <= bus.wdata;
        end
    end

    assign bus.ready = ack_q;
    assign bus.rdata = sel_cmp ? mtimecmp : (sel_time ? mtime : '0);
    assign bus.resp  = acc_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_ERROR;

    assign mtip_o = (mtime >= mtimecmp);

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    typedef logic [63:0] data_t;
    typedef logic [63:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  size_t;

    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_H  = 3'd1,
        LD_W  = 3'd2,
        LD_D  = 3'd3,
        LD_BU = 3'd4,
        LD_HU = 3'd5,
        LD_WU = 3'd6
    } load_type_e;

    typedef enum logic [1:0] {
        ST_B = 2'd0,
        ST_H = 2'd1,
        ST_W = 2'd2,
        ST_D = 2'd3
    } store_type_e;

    localparam size_t SZ_B = 2'd0;
    localparam size_t SZ_H = 2'd1;
    localparam size_t SZ_W = 2'd2;
    localparam size_t SZ_D = 2'd3;

    typedef enum logic [1:0] {
        RESP_OKAY  = 2'b00,
        RESP_ERROR = 2'b10
    } resp_e;

    // One bus word, viewed per lane width.
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } mem_lane_u;

    localparam addr_t CLINT_MTIMECMP_OFS = 64'h0000_0000_0000_4000;
    localparam addr_t CLINT_MTIME_OFS    = 64'h0000_0000_0000_bff8;

endpackage

/* verilog/mem_route.sv */
`timescale 1ns/10ps

module mem_route #(
    parameter mem_pkg::addr_t CLINT_BASE = 64'h0000_0000_0200_0000,
    parameter mem_pkg::addr_t CLINT_SPAN = 64'h0000_0000_0001_0000
) (
    mem_bus_if.slave            cpu_bus,
    mem_bus_if.master           clint_bus,
    output logic                mem_valid_o,
    output logic                mem_write_o,
    output mem_pkg::addr_t      mem_addr_o,
    output mem_pkg::size_t      mem_size_o,
    output mem_pkg::data_t      mem_wdata_o,
    input  logic                mem_ready_i,
    input  mem_pkg::data_t      mem_rdata_i,
    input  mem_pkg::resp_e      mem_resp_i
);

    mem_pkg::addr_t  clint_ofs;
    logic            clint_hit;

    // Below the base wraps to a huge offset and misses.
    assign clint_ofs = cpu_bus.addr - CLINT_BASE;
    assign clint_hit = (clint_ofs < CLINT_SPAN);

    assign clint_bus.valid = cpu_bus.valid & clint_hit;
    assign clint_bus.write = cpu_bus.write;
    assign clint_bus.addr  = clint_ofs;                     // CLINT sees its own offset.
    assign clint_bus.size  = cpu_bus.size;
    assign clint_bus.wdata = cpu_bus.wdata;

    assign mem_valid_o = cpu_bus.valid & ~clint_hit;
    assign mem_write_o = cpu_bus.write;
    assign mem_addr_o  = cpu_bus.addr;
    assign mem_size_o  = cpu_bus.size;
    assign mem_wdata_o = cpu_bus.wdata;

    // Only the selected side can finish the transfer.
    always_comb begin
        if (clint_hit) begin
            cpu_bus.ready = clint_bus.ready;
            cpu_bus.rdata = clint_bus.rdata;
            cpu_bus.resp  = clint_bus.resp;
        end else begin
            cpu_bus.ready = mem_ready_i;
            cpu_bus.rdata = mem_rdata_i;
            cpu_bus.resp  = mem_resp_i;
        end
    end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage #(
    parameter mem_pkg::addr_t CLINT_BASE = 64'h0000_0000_0200_0000,
    parameter mem_pkg::addr_t CLINT_SPAN = 64'h0000_0000_0001_0000,
    parameter int unsigned    TICK_DIV   = 1
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    inst_valid_i,
    input  logic                    mem_read_i,
    input  logic                    mem_write_i,
    input  mem_pkg::load_type_e     load_type_i,
    input  mem_pkg::store_type_e    store_type_i,
    input  logic                    rs2_en_i,
    input  mem_pkg::reg_idx_t       rs2_index_i,
    input  mem_pkg::data_t          rs2_data_i,
    input  mem_pkg::data_t          ex_result_i,
    input  logic                    wb_rd_en_i,
    input  mem_pkg::reg_idx_t       wb_rd_index_i,
    input  mem_pkg::data_t          wb_rd_data_i,
    output mem_pkg::data_t          rd_data_o,
    output logic                    access_ok_o,
    output logic                    fault_o,
    output logic                    mtip_o,
    output logic                    mem_valid_o,
    output logic                    mem_write_o,
    output mem_pkg::addr_t          mem_addr_o,
    output mem_pkg::size_t          mem_size_o,
    output mem_pkg::data_t          mem_wdata_o,
    input  logic                    mem_ready_i,
    input  mem_pkg::data_t          mem_rdata_i,
    input  mem_pkg::resp_e          mem_resp_i
);

    mem_bus_if cpu_bus ();
    mem_bus_if clint_bus ();

    mem_access my_mem_access (
        .inst_valid_i  (inst_valid_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .load_type_i   (load_type_i),
        .store_type_i  (store_type_i),
        .rs2_en_i      (rs2_en_i),
        .rs2_index_i   (rs2_index_i),
        .rs2_data_i    (rs2_data_i),
        .ex_result_i   (ex_result_i),
        .wb_rd_en_i    (wb_rd_en_i),
        .wb_rd_index_i (wb_rd_index_i),
        .wb_rd_data_i  (wb_rd_data_i),
        .rd_data_o     (rd_data_o),
        .access_ok_o   (access_ok_o),
        .fault_o       (fault_o),
        .bus           (cpu_bus.master)
    );

    mem_route #(
        .CLINT_BASE (CLINT_BASE),
        .CLINT_SPAN (CLINT_SPAN)
    ) my_mem_route (
        .cpu_bus     (cpu_bus.slave),
        .clint_bus   (clint_bus.master),
        .mem_valid_o (mem_valid_o),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_size_o  (mem_size_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_resp_i  (mem_resp_i)
    );

    mem_clint #(
        .TICK_DIV (TICK_DIV)
    ) my_mem_clint (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (clint_bus.slave),
        .mtip_o  (mtip_o)
    );

endmodule
